/* src/uart_cmd_pkg.sv */
/*
 * uart command frame definitions: sync and response bytes, opcodes,
 * register map, command word union and response status codes
 */
package uart_cmd_pkg;

    localparam logic [7:0] SYNC_BYTE = 8'hA5; // host to fpga frame start
    localparam logic [7:0] RESP_BYTE = 8'h5A; // fpga to host response start

    typedef enum logic [7:0] {
        OP_REG_WR   = 8'h01,
        OP_REG_RD   = 8'h02,
        OP_BS_WRITE = 8'h10
    } cmd_op_e;

    // register map
    localparam logic [7:0] REG_VER_HI  = 8'h00; // ro
    localparam logic [7:0] REG_VER_LO  = 8'h01; // ro
    localparam logic [7:0] REG_SCRATCH = 8'h02; // rw
    localparam logic [7:0] REG_STATUS  = 8'h03; // ro, {crc err cnt, overflow cnt}

    typedef enum logic [7:0] {
        ST_OK      = 8'd0,
        ST_BAD_CMD = 8'd1,
        ST_CRC_ERR = 8'd2
    } resp_status_e;

    // same 32 bit word, read by register commands or by bitstream writes
    typedef union packed {
        struct packed {
            cmd_op_e     op;
            logic [7:0]  addr;
            logic [15:0] wdata;
        } reg_view;
        struct packed {
            cmd_op_e     op;
            logic [1:0]  slot;
            logic [5:0]  rsvd;
            logic [15:0] len;   // payload bytes
        } bs_view;
    } cmd_word_u;

endpackage

/* src/bitstream_pkg.sv */
/*
 * bitstream path types: session request, session result
 * and the byte beat that goes to the flash writer
 */
package bitstream_pkg;

    // register controller to data processor
    typedef struct packed {
        logic        start;  // one cycle
        logic [1:0]  slot;
        logic [15:0] len;
    } bs_session_t;

    // data processor back to register controller
    typedef struct packed {
        logic valid;    // one cycle, after the last crc byte
        logic crc_err;
        logic overflow;
    } bs_result_t;

    typedef struct packed {
        logic [7:0] data;
        logic       eop;    // last payload byte
    } bs_beat_t;

endpackage

/* src/bs_fifo.sv */
/*
 * synchronous beat fifo with registered read and overflow pulse
 */
`timescale 1ns/1ps
module bs_fifo
    import bitstream_pkg::*;
#(
    parameter int FIFO_DEPTH = 16   // power of two
)(
    input  logic     sys_clk,
    input  logic     rst,
    input  logic     wr_en,
    input  bs_beat_t wr_beat,
    input  logic     rd_req,
    output bs_beat_t rd_beat,
    output logic     rd_valid,
    output logic     not_empty,
    output logic     overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    bs_beat_t      mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr, rd_ptr;   // msb is the wrap bit
    logic          full;
    logic          do_wr, do_rd;

    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign not_empty = (wr_ptr != rd_ptr);
    assign do_wr     = wr_en && !full;       // write while full is dropped
    assign do_rd     = rd_req && not_empty;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            rd_valid <= do_rd;
            overflow <= wr_en && full;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_beat;
        if (do_rd) rd_beat <= mem[rd_ptr[AW-1:0]];
    end

endmodule

/* src/data_process.sv */
/*
 * bitstream payload path: length count, crc-32 over the payload,
 * crc compare against the host value, fifo overflow tracking
 */
`timescale 1ns/1ps
module data_process
    import bitstream_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)(
    input  logic        sys_clk,
    input  logic        rst,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    input  bs_session_t bs_session,
    output bs_result_t  bs_result,
    input  logic        bitstream_fifo_rd_req,
    output bs_beat_t    bs_beat,
    output logic        bitstream_valid,
    output logic        bitstream_fifo_rd_rdy
);

    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // reflected

    typedef enum logic [1:0] {P_IDLE, P_DATA, P_CRC} phase_e;

    phase_e      phase, phase_eff;
    logic [15:0] cnt, cnt_eff;
    logic [31:0] crc, crc_eff;
    logic [31:0] crc_rx;
    logic [1:0]  crc_idx;
    logic        ovf_flag;
    logic        take_data;
    logic        take_crc;
    logic        fifo_wr;
    bs_beat_t    wr_beat;
    logic        fifo_ovf;

    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input logic [7:0] din);
        logic [31:0] c;
        c = crc_in ^ {24'h0, din};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // the first payload byte may share the cycle of the start pulse
    ////////////////////////////////////////////////////////////
    always_comb begin
        phase_eff = phase;
        cnt_eff   = cnt;
        crc_eff   = crc;
        if (bs_session.start) begin
            phase_eff = (bs_session.len == 16'd0) ? P_CRC : P_DATA;
            cnt_eff   = bs_session.len;
            crc_eff   = 32'hFFFF_FFFF;
        end
    end

    assign take_data = rx_valid && (phase_eff == P_DATA);
    assign take_crc  = rx_valid && (phase_eff == P_CRC);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            phase     <= P_IDLE;
            cnt       <= 16'd0;
            crc_idx   <= 2'd0;
            ovf_flag  <= 1'b0;
            fifo_wr   <= 1'b0;
            bs_result <= '0;
        end else begin
            phase     <= phase_eff;
            cnt       <= cnt_eff;
            fifo_wr   <= take_data;  // byte enters the fifo one cycle later
            bs_result <= '0;
            if (bs_session.start) crc_idx <= 2'd0;
            if (bs_session.start) ovf_flag <= 1'b0;
            else if (fifo_ovf) ovf_flag <= 1'b1;
            if (take_data) begin
                cnt <= cnt_eff - 16'd1;
                if (cnt_eff == 16'd1) phase <= P_CRC;
            end
            if (take_crc) begin
                crc_idx <= crc_idx + 2'd1;
                if (crc_idx == 2'd3) begin
                    phase     <= P_IDLE;
                    bs_result <= '{valid:    1'b1,
                                   crc_err:  ({crc_rx[23:0], rx_data} != ~crc_eff),
                                   overflow: ovf_flag};
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        crc <= take_data ? crc32_byte(crc_eff, rx_data) : crc_eff;
        if (take_crc) crc_rx <= {crc_rx[23:0], rx_data};  // msb first
        if (take_data) wr_beat <= '{data: rx_data, eop: (cnt_eff == 16'd1)};
    end

    bs_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_bs_fifo (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .wr_en     (fifo_wr),
        .wr_beat   (wr_beat),
        .rd_req    (bitstream_fifo_rd_req),
        .rd_beat   (bs_beat),
        .rd_valid  (bitstream_valid),
        .not_empty (bitstream_fifo_rd_rdy),
        .overflow  (fifo_ovf)
    );

endmodule

/* src/uart_reg_ctrl.sv */
/*
 * uart command parser: sync hunt, command word assembly, register file,
 * bitstream session control and 4 byte response sender
 */
`timescale 1ns/1ps
module uart_reg_ctrl
    import uart_cmd_pkg::*;
    import bitstream_pkg::*;
#(
    parameter logic [31:0] FPGA_VERSION       = 32'h2019_0101,
    parameter int          USER_BITSTREAM_CNT = 3
)(
    input  logic        sys_clk,
    input  logic        rst,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    input  logic        tx_ready,
    output bs_session_t bs_session,
    input  bs_result_t  bs_result,
    output logic        flash_wr_en,
    output logic [1:0]  bitstream_wr_num
);

    typedef enum logic [2:0] {
        S_HUNT, S_CMD, S_DECODE, S_SESSION, S_RESP
    } state_e;

    state_e       state;
    logic [1:0]   byte_cnt;
    logic [1:0]   resp_cnt;
    cmd_word_u    cmd_word;
    cmd_word_u    cmd_next;
    logic [31:0]  resp_sr;
    logic         start_q;
    logic [1:0]   slot_q;
    logic [15:0]  scratch;
    logic [7:0]   crc_err_cnt;
    logic [7:0]   ovf_cnt;
    resp_status_e resp_status;
    logic [15:0]  resp_value;
    logic         scratch_we;
    logic         bs_ok;
    logic         resp_load;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////
    assign cmd_next = {cmd_word[23:0], rx_data};   // word as it will be after this byte
    assign bs_ok    = (cmd_next.bs_view.op == OP_BS_WRITE) &&
                      (32'(cmd_next.bs_view.slot) < USER_BITSTREAM_CNT);

    always_comb begin
        resp_status = ST_BAD_CMD;
        resp_value  = 16'h0;
        scratch_we  = 1'b0;
        case (cmd_word.reg_view.op)
            OP_REG_RD: begin
                resp_status = ST_OK;
                case (cmd_word.reg_view.addr)
                    REG_VER_HI:  resp_value = FPGA_VERSION[31:16];
                    REG_VER_LO:  resp_value = FPGA_VERSION[15:0];
                    REG_SCRATCH: resp_value = scratch;
                    REG_STATUS:  resp_value = {crc_err_cnt, ovf_cnt};
                    default:     resp_status = ST_BAD_CMD;
                endcase
            end
            OP_REG_WR: begin
                if (cmd_word.reg_view.addr == REG_SCRATCH) begin
                    resp_status = ST_OK;
                    resp_value  = cmd_word.reg_view.wdata;
                    scratch_we  = (state == S_DECODE);
                end
            end
            default: ;  // rejects, bad bitstream slot included
        endcase
        // session end overrides the register decode
        if (state == S_SESSION) begin
            resp_status = (bs_result.crc_err || bs_result.overflow) ? ST_CRC_ERR : ST_OK;
            resp_value  = cmd_word.bs_view.len;
        end
    end

    assign resp_load = (state == S_DECODE) || (state == S_SESSION && bs_result.valid);

    ////////////////////////////////////////////////////////////
    // control fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state       <= S_HUNT;
            byte_cnt    <= 2'd0;
            resp_cnt    <= 2'd0;
            tx_valid    <= 1'b0;
            start_q     <= 1'b0;
            slot_q      <= 2'd0;
            scratch     <= 16'h0;
            crc_err_cnt <= 8'h0;
            ovf_cnt     <= 8'h0;
        end else begin
            start_q <= 1'b0;
            if (scratch_we) scratch <= cmd_word.reg_view.wdata;
            if (resp_load) begin
                tx_valid <= 1'b1;
                resp_cnt <= 2'd0;
            end
            case (state)
                S_HUNT: if (rx_valid && rx_data == SYNC_BYTE) begin
                    state    <= S_CMD;
                    byte_cnt <= 2'd0;
                end
                S_CMD: if (rx_valid) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) begin
                        state   <= bs_ok ? S_SESSION : S_DECODE;
                        start_q <= bs_ok;
                        if (bs_ok) slot_q <= cmd_next.bs_view.slot;
                    end
                end
                S_DECODE: state <= S_RESP;
                S_SESSION: if (bs_result.valid) begin
                    state       <= S_RESP;
                    crc_err_cnt <= crc_err_cnt + 8'(bs_result.crc_err);
                    ovf_cnt     <= ovf_cnt + 8'(bs_result.overflow);
                end
                S_RESP: if (tx_ready) begin   // tx_valid is high here
                    resp_cnt <= resp_cnt + 2'd1;
                    if (resp_cnt == 2'd3) begin
                        tx_valid <= 1'b0;
                        state    <= S_HUNT;
                    end
                end
                default: state <= S_HUNT;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge sys_clk) begin
        if (state == S_CMD && rx_valid) cmd_word <= cmd_next;
        if (resp_load) begin
            resp_sr <= {RESP_BYTE, resp_status, resp_value};
        end else if (tx_valid && tx_ready) begin
            resp_sr <= {resp_sr[23:0], 8'h00};
        end
    end

    assign tx_data          = resp_sr[31:24];
    assign flash_wr_en      = (state == S_SESSION);
    assign bitstream_wr_num = slot_q;
    assign bs_session       = '{start: start_q, slot: slot_q, len: cmd_word.bs_view.len};

endmodule

/* src/data_ctrl.sv */
/*
 * top level: uart register controller and bitstream data processor
 */
`timescale 1ns/1ps
module data_ctrl
    import bitstream_pkg::*;
#(
    parameter logic [31:0] FPGA_VERSION       = 32'h2019_0101,
    parameter int          USER_BITSTREAM_CNT = 3,
    parameter int          FIFO_DEPTH         = 16
)(
    input  logic       sys_clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       flash_wr_en,
    output logic [1:0] bitstream_wr_num,
    input  logic       bitstream_fifo_rd_req,
    output logic [7:0] bitstream_data,
    output logic       bitstream_valid,
    output logic       bitstream_eop,
    output logic       bitstream_fifo_rd_rdy
);

    bs_session_t bs_session;
    bs_result_t  bs_result;
    bs_beat_t    bs_beat;

    uart_reg_ctrl #(
        .FPGA_VERSION       (FPGA_VERSION),
        .USER_BITSTREAM_CNT (USER_BITSTREAM_CNT)
    ) u_uart_reg_ctrl (
        .sys_clk          (sys_clk),
        .rst              (rst),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .tx_data          (tx_data),
        .tx_valid         (tx_valid),
        .tx_ready         (tx_ready),
        .bs_session       (bs_session),
        .bs_result        (bs_result),
        .flash_wr_en      (flash_wr_en),
        .bitstream_wr_num (bitstream_wr_num)
    );

    // sees the same rx stream, acts only inside a session
    data_process #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_data_process (
        .sys_clk               (sys_clk),
        .rst                   (rst),
        .rx_data               (rx_data),
        .rx_valid              (rx_valid),
        .bs_session            (bs_session),
        .bs_result             (bs_result),
        .bitstream_fifo_rd_req (bitstream_fifo_rd_req),
        .bs_beat               (bs_beat),
        .bitstream_valid       (bitstream_valid),
        .bitstream_fifo_rd_rdy (bitstream_fifo_rd_rdy)
    );

    assign bitstream_data = bs_beat.data;
    assign bitstream_eop  = bs_beat.eop;

endmodule

/* verification/tb_checks.svh */
/*
 * testbench helpers: lfsr step, bitwise crc-32 model,
 * error stop and typed compare tasks
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one byte into a reflected crc-32, one bit at a time, lsb of the byte first
function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ b[i];
        c  = {1'b0, c[31:1]};
        if (fb) c = c ^ 32'hEDB8_8320;
    end
    return c;
endfunction

task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
endtask

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////
task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
        stop_on_error($sformatf("** Error: %s expected %h actual %h", name, exp, act));
endtask

task automatic check_status(input string name, input resp_status_e exp, input resp_status_e act);
    if (act !== exp)
        stop_on_error($sformatf("** Error: %s status expected %0d actual %0d", name, exp, act));
endtask

task automatic check_beat(input string name, input bs_beat_t exp, input bs_beat_t act);
    if (act !== exp)
        stop_on_error($sformatf("** Error: %s beat expected %h/%b actual %h/%b",
                                name, exp.data, exp.eop, act.data, act.eop));
endtask

task automatic check_slot(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
        stop_on_error($sformatf("** Error: %s slot expected %0d actual %0d", name, exp, act));
endtask

`endif

/* verification/tb_data_ctrl.sv */
/*
 * testbench for data_ctrl with host frames on rx, response collection on tx,
 * flash side bitstream puller with crc model and watchdog
 */
`timescale 1ns/1ps
module tb_data_ctrl
    import uart_cmd_pkg::*;
    import bitstream_pkg::*;
;

    localparam logic [31:0] VERSION      = 32'h2019_0101;
    localparam int          N_BS         = 6;   // good bitstream writes
    localparam int          N_FRAMES     = N_BS + 10;  // 8 register frames, bad crc write, status
    localparam int          RESET_CYCLES = 3;

    logic       sys_clk;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       flash_wr_en;
    logic [1:0] bitstream_wr_num;
    logic       bitstream_fifo_rd_req;
    logic [7:0] bitstream_data;
    logic       bitstream_valid;
    logic       bitstream_eop;
    logic       bitstream_fifo_rd_rdy;

    logic [15:0] lfsr_state;
    logic [7:0]  resp_q [$];      // bytes taken from tx
    bs_beat_t    exp_beats [$];   // payload still expected at the flash side
    bs_beat_t    got_beat;
    bs_beat_t    want_beat;
    string       cur_test;
    logic [1:0]  exp_slot;
    logic        in_bs;
    logic        wr_en_seen;      // flash_wr_en observed during the current write
    logic [7:0]  crc_errs;

    `include "tb_checks.svh"

    data_ctrl #(
        .FPGA_VERSION       (VERSION),
        .USER_BITSTREAM_CNT (3),
        .FIFO_DEPTH         (16)
    ) u_dut (
        .sys_clk               (sys_clk),
        .rst                   (rst),
        .rx_data               (rx_data),
        .rx_valid              (rx_valid),
        .tx_data               (tx_data),
        .tx_valid              (tx_valid),
        .tx_ready              (tx_ready),
        .flash_wr_en           (flash_wr_en),
        .bitstream_wr_num      (bitstream_wr_num),
        .bitstream_fifo_rd_req (bitstream_fifo_rd_req),
        .bitstream_data        (bitstream_data),
        .bitstream_valid       (bitstream_valid),
        .bitstream_eop         (bitstream_eop),
        .bitstream_fifo_rd_rdy (bitstream_fifo_rd_rdy)
    );

    always #50 sys_clk = ~sys_clk;

    ////////////////////////////////////////////////////////////
    // all random draws happen in the stimulus process
    ////////////////////////////////////////////////////////////
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // one clock with fresh tx and flash side back-pressure
    task automatic tick();
        logic [31:0] r;
        @(posedge sys_clk);
        draw_bits(3, r);
        rx_valid              <= 1'b0;
        tx_ready              <= r[0];          // about half
        bitstream_fifo_rd_req <= r[1] | r[2];   // about three quarters
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [31:0] gap;
        draw_bits(2, gap);
        repeat (gap[1:0]) tick();
        tick();
        rx_data  <= b;   // overrides the idle drive of this tick
        rx_valid <= 1'b1;
    endtask

    task automatic send_word(input logic [31:0] w);
        if (resp_q.size() != 0)
            stop_on_error("response bytes arrived with no command outstanding");
        send_byte(SYNC_BYTE);
        for (int i = 3; i >= 0; i--) send_byte(w[8*i +: 8]);
    endtask

    task automatic expect_response(input resp_status_e st, input logic [15:0] val);
        logic [7:0] b [4];
        while (resp_q.size() < 4) tick();
        for (int i = 0; i < 4; i++) b[i] = resp_q.pop_front();
        check_byte({cur_test, " sync"}, RESP_BYTE, b[0]);
        check_status(cur_test, st, resp_status_e'(b[1]));
        check_byte({cur_test, " data hi"}, val[15:8], b[2]);
        check_byte({cur_test, " data lo"}, val[7:0], b[3]);
    endtask

    task automatic reg_access(input string name, input logic [7:0] op, input logic [7:0] addr,
                              input logic [15:0] wdata, input resp_status_e st,
                              input logic [15:0] val);
        cur_test = name;
        send_word({op, addr, wdata});
        expect_response(st, val);
    endtask

    task automatic bs_write(input string name, input logic [1:0] slot, input int len,
                            input logic corrupt);
        logic [31:0] r;
        logic [31:0] crc;
        logic [7:0]  d;
        cur_test   = name;
        exp_slot   = slot;
        in_bs      = 1'b1;
        wr_en_seen = 1'b0;
        send_word({OP_BS_WRITE, slot, 6'd0, 16'(len)});
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            draw_bits(8, r);
            d = r[7:0];
            exp_beats.push_back('{data: d, eop: (i == len - 1)});
            crc = crc32_update(crc, d);
            send_byte(d);
        end
        crc = ~crc;
        if (corrupt) crc = crc ^ 32'h0000_0100;
        for (int i = 3; i >= 0; i--) send_byte(crc[8*i +: 8]);  // msb first
        expect_response(corrupt ? ST_CRC_ERR : ST_OK, 16'(len));
        if (!wr_en_seen)
            stop_on_error("flash_wr_en never went high during the bitstream write");
        while (exp_beats.size() != 0) tick();   // flash side drains the fifo
        in_bs = 1'b0;
        if (corrupt) crc_errs = crc_errs + 8'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // monitors sample mid cycle
    ////////////////////////////////////////////////////////////
    always @(negedge sys_clk) begin
        if (!rst && tx_valid && tx_ready) resp_q.push_back(tx_data);
    end

    always @(negedge sys_clk) begin
        if (!rst && bitstream_valid) begin
            if (exp_beats.size() == 0) begin
                stop_on_error("bitstream byte seen with no payload byte outstanding");
            end else begin
                want_beat = exp_beats.pop_front();
                got_beat  = '{data: bitstream_data, eop: bitstream_eop};
                check_beat(cur_test, want_beat, got_beat);
            end
        end
        if (!rst && exp_beats.size() == 0 && bitstream_fifo_rd_rdy)
            stop_on_error("fifo reports data with no payload byte outstanding");
    end

    always @(negedge sys_clk) begin
        if (!rst && flash_wr_en) begin
            if (!in_bs) begin
                stop_on_error("flash_wr_en went high outside a bitstream write");
            end else begin
                wr_en_seen = 1'b1;
                check_slot(cur_test, exp_slot, bitstream_wr_num);
            end
        end
    end

    // watchdog allows 2000 cycles per frame
    initial begin
        repeat (RESET_CYCLES + 2000 * N_FRAMES) @(posedge sys_clk);
        stop_on_error("timeout: the run hung, a frame never completed");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [15:0] scratch_val;
        sys_clk               = 1'b0;
        rst                   = 1'b1;
        rx_data               = 8'h00;
        rx_valid              = 1'b0;
        tx_ready              = 1'b0;
        bitstream_fifo_rd_req = 1'b0;
        lfsr_state            = 16'd67;
        cur_test              = "reset";
        exp_slot              = 2'd0;
        in_bs                 = 1'b0;
        wr_en_seen            = 1'b0;
        crc_errs              = 8'h00;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        rst <= 1'b0;
        @(negedge sys_clk);
        if ({tx_valid, bitstream_valid, flash_wr_en, bitstream_fifo_rd_rdy} !== 4'b0000)
            stop_on_error("outputs are not idle after reset");

        reg_access("read ver hi", OP_REG_RD, REG_VER_HI, 16'h0, ST_OK, VERSION[31:16]);
        reg_access("read ver lo", OP_REG_RD, REG_VER_LO, 16'h0, ST_OK, VERSION[15:0]);
        reg_access("scratch after reset", OP_REG_RD, REG_SCRATCH, 16'h0, ST_OK, 16'h0);

        draw_bits(16, r);
        scratch_val = r[15:0];
        reg_access("write scratch", OP_REG_WR, REG_SCRATCH, scratch_val, ST_OK, scratch_val);
        reg_access("read scratch", OP_REG_RD, REG_SCRATCH, 16'h0, ST_OK, scratch_val);
        reg_access("write ver lo", OP_REG_WR, REG_VER_LO, 16'h1234, ST_BAD_CMD, 16'h0);
        reg_access("unknown opcode", 8'h33, REG_SCRATCH, 16'h5555, ST_BAD_CMD, 16'h0);
        // slot 3 sits in the top two bits of the second byte
        reg_access("bitstream slot 3", OP_BS_WRITE, 8'hC0, 16'd8, ST_BAD_CMD, 16'h0);

        for (int i = 0; i < N_BS; i++) begin
            draw_bits(6, r);
            bs_write($sformatf("bitstream %0d", i), 2'(i % 3), 1 + int'(r[5:0]) % 40, 1'b0);
        end

        draw_bits(6, r);
        bs_write("bitstream bad crc", 2'd1, 1 + int'(r[5:0]) % 40, 1'b1);
        reg_access("read status", OP_REG_RD, REG_STATUS, 16'h0, ST_OK, {crc_errs, 8'h00});

        repeat (20) tick();
        if (resp_q.size() != 0 || exp_beats.size() != 0) begin
            stop_on_error("extra response bytes or missing bitstream bytes at end of run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+verification
src/uart_cmd_pkg.sv
src/bitstream_pkg.sv
src/bs_fifo.sv
src/data_process.sv
src/uart_reg_ctrl.sv
src/data_ctrl.sv
verification/tb_data_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the data_ctrl testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sim.f --top-module tb_data_ctrl -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
